// File: logic/cpu_ifs.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

// Fetch to decode, stall is the only back-pressure in the core
interface fetch_dec_if;
   logic                 valid;
   logic [`CPU_XLEN-1:0] pc;
   logic [`CPU_XLEN-1:0] instr;
   logic                 stall;

   modport fetch (output valid, pc, instr, input stall);
   modport decode (input valid, pc, instr, output stall);
endinterface

// Decoded item with both register operands
interface dec_exe_if;
   logic                 valid;
   logic [`CPU_XLEN-1:0] pc;
   logic [`CPU_XLEN-1:0] instr;
   logic [`CPU_XLEN-1:0] val_a;
   logic [`CPU_XLEN-1:0] val_b;

   modport source (output valid, pc, instr, val_a, val_b);
   modport sink (input valid, pc, instr, val_a, val_b);
endinterface

interface exe_mem_if;
   logic                 valid;
   logic [`CPU_OP_W-1:0] opcode;
   logic [`CPU_RA_W-1:0] rd;
   // ALU output, memory address or immediate
   logic [`CPU_XLEN-1:0] result;
   logic [`CPU_XLEN-1:0] store_data;

   modport source (output valid, opcode, rd, result, store_data);
   modport sink (input valid, opcode, rd, result, store_data);
endinterface

// Write back into the register file and scoreboard
interface wb_if;
   logic                 valid;
   logic                 we;
   logic [`CPU_RA_W-1:0] rd;
   logic [`CPU_XLEN-1:0] data;
   logic                 halt;

   modport source (output valid, we, rd, data, halt);
   modport sink (input valid, we, rd, data, halt);
endinterface

// File: logic/cpu_pkg.sv
package cpu_pkg;

`include "cpu_settings.svh"

   // Register view, rd = rs0 op rs1
   typedef struct packed {
      logic [`CPU_OP_W-1:0]  opcode;
      logic [`CPU_RA_W-1:0]  rd;
      logic [`CPU_RA_W-1:0]  rs0;
      logic [`CPU_RA_W-1:0]  rs1;
      logic [`CPU_ALU_W-1:0] alu_op;
      logic [`CPU_XLEN-`CPU_OP_W-3*`CPU_RA_W-`CPU_ALU_W-1:0] unused;
   } instr_reg_t;

   // Immediate view for loads, stores, jumps
   typedef struct packed {
      logic [`CPU_OP_W-1:0]  opcode;
      logic [`CPU_RA_W-1:0]  rd;
      logic [`CPU_RA_W-1:0]  rs0;
      logic [`CPU_IMM_W-1:0] imm;
   } instr_imm_t;

   typedef union packed {
      instr_reg_t r;
      instr_imm_t i;
   } instr_u;

endpackage

// File: logic/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath sizes
`define CPU_XLEN      32
`define CPU_NREGS     32
`define CPU_RA_W      5
`define CPU_OP_W      5
`define CPU_ALU_W     5
`define CPU_IMM_W     17
`define CPU_RESET_PC  32'd0

// Opcodes, anything else runs as a no-op
`define OP_NOP    5'd0
`define OP_LOADI  5'd1
`define OP_LOAD   5'd2
`define OP_STORE  5'd3
`define OP_ALU    5'd4
`define OP_JUMPZ  5'd5
`define OP_HALT   5'd6

// ALU function codes
`define ALU_ADD   5'd0
`define ALU_SUB   5'd1
`define ALU_AND   5'd2
`define ALU_OR    5'd3
`define ALU_XOR   5'd4
`define ALU_SLL   5'd5
`define ALU_SRL   5'd6
`define ALU_SLT   5'd7

`endif

// File: logic/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_top (
   input  logic                 clk,
   input  logic                 rst_n,
   output logic [`CPU_XLEN-1:0] imem_addr,
   input  logic [`CPU_XLEN-1:0] imem_data,
   output logic [`CPU_XLEN-1:0] dmem_addr,
   output logic [`CPU_XLEN-1:0] dmem_wdata,
   output logic                 dmem_we,
   input  logic [`CPU_XLEN-1:0] dmem_rdata,
   output logic                 halted
);

   // Jump resolved in execute
   logic                 redirect;
   logic [`CPU_XLEN-1:0] redirect_pc;

   fetch_dec_if fd_bus ();
   dec_exe_if   de_bus ();
   exe_mem_if   em_bus ();
   wb_if        wb_bus ();

   fetch_stage fetch_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .imem_addr   (imem_addr),
      .imem_data   (imem_data),
      .fd          (fd_bus.fetch)
   );

   decode_stage decode_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .redirect (redirect),
      .fd       (fd_bus.decode),
      .de       (de_bus.source),
      .wb       (wb_bus.sink)
   );

   execute_stage execute_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .de          (de_bus.sink),
      .em          (em_bus.source),
      .redirect    (redirect),
      .redirect_pc (redirect_pc)
   );

   memory_stage memory_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .em         (em_bus.sink),
      .wb         (wb_bus.source),
      .dmem_addr  (dmem_addr),
      .dmem_wdata (dmem_wdata),
      .dmem_we    (dmem_we),
      .dmem_rdata (dmem_rdata),
      .halted     (halted)
   );

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decode_stage import cpu_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        redirect,
   fetch_dec_if.decode fd,
   dec_exe_if.source   de,
   wb_if.sink          wb
);

   logic [`CPU_XLEN-1:0]  regs [`CPU_NREGS];
   logic [`CPU_NREGS-1:0] pending;
   logic [`CPU_NREGS-1:0] wb_clear;
   logic [`CPU_NREGS-1:0] busy;
   logic [`CPU_NREGS-1:0] issue_set;
   logic                  halt_sent;
   instr_u                ins;
   logic [`CPU_OP_W-1:0]  opcode;
   logic [`CPU_RA_W-1:0]  src_b;
   logic [`CPU_XLEN-1:0]  val_a;
   logic [`CPU_XLEN-1:0]  val_b;
   logic                  chk_rs0;
   logic                  chk_rs1;
   logic                  chk_rd;
   logic                  writes_rd;
   logic                  hazard;
   logic                  is_halt;
   logic                  issue;
   logic                  wb_write;

   // r0 reads zero, a write in this cycle passes through
   function automatic logic [`CPU_XLEN-1:0] read_reg(input logic [`CPU_RA_W-1:0] ra);
      if (ra == '0) begin
         return '0;
      end
      if (wb_write && wb.rd == ra) begin
         return wb.data;
      end
      return regs[ra];
   endfunction

   assign ins    = fd.instr;
   assign opcode = ins.i.opcode;
   // Second source is rs1 for ALU ops and rd otherwise
   assign src_b  = (opcode == `OP_ALU) ? ins.r.rs1 : ins.i.rd;

   always_comb begin
      val_a = read_reg(ins.i.rs0);
      val_b = read_reg(src_b);
   end

   // Which registers the held word depends on
   always_comb begin
      chk_rs0   = 1'b0;
      chk_rs1   = 1'b0;
      chk_rd    = 1'b0;
      writes_rd = 1'b0;
      case (opcode)
         `OP_LOADI: begin
            chk_rd    = 1'b1;
            writes_rd = 1'b1;
         end
         `OP_LOAD: begin
            chk_rs0   = 1'b1;
            chk_rd    = 1'b1;
            writes_rd = 1'b1;
         end
         `OP_STORE, `OP_JUMPZ: begin
            chk_rs0 = 1'b1;
            chk_rd  = 1'b1;
         end
         `OP_ALU: begin
            chk_rs0   = 1'b1;
            chk_rs1   = 1'b1;
            chk_rd    = 1'b1;
            writes_rd = 1'b1;
         end
         default: ;
      endcase
   end

   // Scoreboard bits retiring this cycle no longer block
   assign wb_write = wb.valid && wb.we;

   always_comb begin
      wb_clear = '0;
      if (wb_write) begin
         wb_clear[wb.rd] = 1'b1;
      end
   end

   assign busy    = pending & ~wb_clear;
   // rd check also keeps two writes to one register in order
   assign hazard  = (chk_rs0 && busy[ins.i.rs0]) || (chk_rs1 && busy[ins.r.rs1])
                 || (chk_rd && busy[ins.i.rd]);
   assign is_halt = (opcode == `OP_HALT);

   // HALT goes down once, then decode sits on it
   assign fd.stall = fd.valid && (hazard || is_halt);
   assign issue    = fd.valid && !hazard && !halt_sent && !redirect;

   always_comb begin
      issue_set = '0;
      if (issue && writes_rd && ins.i.rd != '0) begin
         issue_set[ins.i.rd] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wb_write && wb.rd != '0) begin
         regs[wb.rd] <= wb.data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pending   <= '0;
         halt_sent <= 1'b0;
         de.valid  <= 1'b0;
      end else begin
         pending  <= busy | issue_set;
         de.valid <= issue;
         if (issue && is_halt) begin
            halt_sent <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         de.pc    <= fd.pc;
         de.instr <= fd.instr;
         de.val_a <= val_a;
         de.val_b <= val_b;
      end
   end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module execute_stage import cpu_pkg::*; (
   input  logic                 clk,
   input  logic                 rst_n,
   dec_exe_if.sink              de,
   exe_mem_if.source            em,
   output logic                 redirect,
   output logic [`CPU_XLEN-1:0] redirect_pc
);

   localparam int SHAMT_W = $clog2(`CPU_XLEN);

   instr_u               ins;
   logic [`CPU_XLEN-1:0] imm_ext;
   logic [`CPU_XLEN-1:0] addr;
   logic [`CPU_XLEN-1:0] alu_out;
   logic [`CPU_XLEN-1:0] result;
   logic [SHAMT_W-1:0]   shamt;

   assign ins     = de.instr;
   assign imm_ext = {{(`CPU_XLEN-`CPU_IMM_W){ins.i.imm[`CPU_IMM_W-1]}}, ins.i.imm};
   // Shared by loads, stores and the jump target
   assign addr    = de.val_a + imm_ext;
   assign shamt   = de.val_b[SHAMT_W-1:0];

   always_comb begin
      case (ins.r.alu_op)
         `ALU_ADD: alu_out = de.val_a + de.val_b;
         `ALU_SUB: alu_out = de.val_a - de.val_b;
         `ALU_AND: alu_out = de.val_a & de.val_b;
         `ALU_OR:  alu_out = de.val_a | de.val_b;
         `ALU_XOR: alu_out = de.val_a ^ de.val_b;
         `ALU_SLL: alu_out = de.val_a << shamt;
         `ALU_SRL: alu_out = de.val_a >> shamt;
         `ALU_SLT: alu_out = {{(`CPU_XLEN-1){1'b0}}, $signed(de.val_a) < $signed(de.val_b)};
         default:  alu_out = '0;
      endcase
   end

   always_comb begin
      case (ins.i.opcode)
         `OP_LOADI:           result = imm_ext;
         `OP_LOAD, `OP_STORE: result = addr;
         `OP_ALU:             result = alu_out;
         // Non-data ops carry their own PC down the pipe
         default:             result = de.pc;
      endcase
   end

   // Taken jump, decode and fetch drop the two younger words
   assign redirect    = de.valid && ins.i.opcode == `OP_JUMPZ && de.val_b == '0;
   assign redirect_pc = addr;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         em.valid <= 1'b0;
      end else begin
         em.valid <= de.valid;
      end
   end

   always_ff @(posedge clk) begin
      em.opcode     <= ins.i.opcode;
      em.rd         <= ins.i.rd;
      em.result     <= result;
      em.store_data <= de.val_b;
   end

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module fetch_stage (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 redirect,
   input  logic [`CPU_XLEN-1:0] redirect_pc,
   output logic [`CPU_XLEN-1:0] imem_addr,
   input  logic [`CPU_XLEN-1:0] imem_data,
   fetch_dec_if.fetch           fd
);

   logic [`CPU_XLEN-1:0] pc;

   // Instruction memory answers in the same cycle
   assign imem_addr = pc;

   // PC and valid flag
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc       <= `CPU_RESET_PC;
         fd.valid <= 1'b0;
      end else if (redirect) begin
         // Word in flight is younger than the jump
         pc       <= redirect_pc;
         fd.valid <= 1'b0;
      end else if (!fd.stall) begin
         pc       <= pc + 1'b1;
         fd.valid <= 1'b1;
      end
   end

   // Fetched word, held while decode stalls
   always_ff @(posedge clk) begin
      if (!fd.stall) begin
         fd.pc    <= pc;
         fd.instr <= imem_data;
      end
   end

endmodule

// File: logic/memory_stage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module memory_stage (
   input  logic                 clk,
   input  logic                 rst_n,
   exe_mem_if.sink              em,
   wb_if.source                 wb,
   output logic [`CPU_XLEN-1:0] dmem_addr,
   output logic [`CPU_XLEN-1:0] dmem_wdata,
   output logic                 dmem_we,
   input  logic [`CPU_XLEN-1:0] dmem_rdata,
   output logic                 halted
);

   logic is_load;

   // Data memory reads in this cycle, the write lands on the edge
   assign dmem_addr  = em.result;
   assign dmem_wdata = em.store_data;
   assign dmem_we    = em.valid && em.opcode == `OP_STORE;

   assign is_load = (em.opcode == `OP_LOAD);

   assign wb.valid = em.valid;
   assign wb.rd    = em.rd;
   assign wb.data  = is_load ? dmem_rdata : em.result;
   assign wb.halt  = em.valid && em.opcode == `OP_HALT;

   always_comb begin
      case (em.opcode)
         `OP_LOADI, `OP_LOAD, `OP_ALU: wb.we = em.valid;
         default:                      wb.we = 1'b0;
      endcase
   end

   // Sticky until the next reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         halted <= 1'b0;
      end else if (wb.halt) begin
         halted <= 1'b1;
      end
   end

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f sources.f --top-module cpu_tb -o cpu_sim \
   > build.log 2>&1 && ./obj_dir/cpu_sim > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "Simulation did not pass"; exit 1; }
echo "Simulation passed"
exit 0

// File: sim/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_tb import cpu_pkg::*; ();

   localparam int N_ALU     = 13;
   localparam int N_FIXED   = 3;
   localparam int MEM_WORDS = 64;
   localparam int MAX_TIME  = (N_ALU + N_FIXED) * 80 * 4;

   logic                 clk;
   logic                 rst_n;
   logic [`CPU_XLEN-1:0] imem_addr;
   logic [`CPU_XLEN-1:0] imem_data;
   logic [`CPU_XLEN-1:0] dmem_addr;
   logic [`CPU_XLEN-1:0] dmem_wdata;
   logic                 dmem_we;
   logic [`CPU_XLEN-1:0] dmem_rdata;
   logic                 halted;

   logic [`CPU_XLEN-1:0] imem [MEM_WORDS];
   logic [`CPU_XLEN-1:0] dmem [MEM_WORDS];
   logic [`CPU_XLEN-1:0] log_addr [$];
   logic [`CPU_XLEN-1:0] log_data [$];
   logic [`CPU_XLEN-1:0] exp_addr_q [$];
   logic [`CPU_XLEN-1:0] exp_data_q [$];

   // ALU stimulus table
   string                tc_name [N_ALU];
   logic [`CPU_ALU_W-1:0] tc_code [N_ALU];
   logic [`CPU_XLEN-1:0] tc_a [N_ALU];
   logic [`CPU_XLEN-1:0] tc_b [N_ALU];
   logic [`CPU_XLEN-1:0] tc_addr [N_ALU];
   logic [`CPU_XLEN-1:0] tc_res [N_ALU];
   integer               seed;

   cpu_top cpu_top_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .imem_addr  (imem_addr),
      .imem_data  (imem_data),
      .dmem_addr  (dmem_addr),
      .dmem_wdata (dmem_wdata),
      .dmem_we    (dmem_we),
      .dmem_rdata (dmem_rdata),
      .halted     (halted)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   assign imem_data  = imem[imem_addr[5:0]];
   assign dmem_rdata = dmem[dmem_addr[5:0]];

   // Data memory with a store log, refilled during reset
   always @(posedge clk) begin
      if (!rst_n) begin
         for (int a = 0; a < MEM_WORDS; a++) begin
            dmem[a] <= {a[15:0] ^ 16'hc3a5, ~a[15:0]};
         end
         log_addr.delete();
         log_data.delete();
      end else if (dmem_we) begin
         dmem[dmem_addr[5:0]] <= dmem_wdata;
         log_addr.push_back(dmem_addr);
         log_data.push_back(dmem_wdata);
      end
   end

   initial begin
      #(MAX_TIME * 1ns);
      $display("Watchdog expired, the core never halted");
      $display("CHECKS FAILED");
      $fatal(1);
   end

   function automatic instr_u asm_imm(input logic [4:0] op, input logic [4:0] rd,
                                      input logic [4:0] rs0, input logic [`CPU_XLEN-1:0] imm);
      instr_u w;
      w.i.opcode = op;
      w.i.rd     = rd;
      w.i.rs0    = rs0;
      w.i.imm    = imm[`CPU_IMM_W-1:0];
      return w;
   endfunction

   function automatic instr_u asm_alu(input logic [4:0] rd, input logic [4:0] rs0,
                                      input logic [4:0] rs1, input logic [4:0] fn);
      instr_u w;
      w          = '0;
      w.r.opcode = `OP_ALU;
      w.r.rd     = rd;
      w.r.rs0    = rs0;
      w.r.rs1    = rs1;
      w.r.alu_op = fn;
      return w;
   endfunction

   function automatic logic [`CPU_XLEN-1:0] alu_ref(input logic [4:0] fn,
                                                    input logic [`CPU_XLEN-1:0] a,
                                                    input logic [`CPU_XLEN-1:0] b);
      case (fn)
         `ALU_ADD: return a + b;
         `ALU_SUB: return a - b;
         `ALU_AND: return a & b;
         `ALU_OR:  return a | b;
         `ALU_XOR: return a ^ b;
         `ALU_SLL: return a << b[4:0];
         `ALU_SRL: return a >> b[4:0];
         `ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         default:  return '0;
      endcase
   endfunction

   task automatic check_addr(input string name, input logic [`CPU_XLEN-1:0] exp,
                             input logic [`CPU_XLEN-1:0] act);
      if (exp !== act) begin
         $display("[ERROR] %s address expected %h actual %h", name, exp, act);
         $display("CHECKS FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_data(input string name, input logic [`CPU_XLEN-1:0] exp,
                             input logic [`CPU_XLEN-1:0] act);
      if (exp !== act) begin
         $display("[ERROR] %s data expected %h actual %h", name, exp, act);
         $display("CHECKS FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_instr(input string name, input instr_u exp, input instr_u act);
      if (exp !== act) begin
         $display("[ERROR] %s fetch word expected %h actual %h", name, exp, act);
         $display("CHECKS FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("[ERROR] %s flag expected %b actual %b", name, exp, act);
         $display("CHECKS FAILED");
         $fatal(1);
      end
   endtask

   task automatic clear_program();
      for (int a = 0; a < MEM_WORDS; a++) begin
         imem[a] = asm_imm(`OP_NOP, 5'd0, 5'd0, '0);
      end
      exp_addr_q.delete();
      exp_data_q.delete();
   endtask

   // Reset, run to HALT, then make sure nothing moves afterwards
   task automatic run_core(input string name, input int watch_pc, input instr_u watch_word);
      logic [`CPU_XLEN-1:0] prev_addr;
      bit                   watched;
      @(posedge clk);
      #1 rst_n = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      check_addr(name, `CPU_RESET_PC, imem_addr);
      check_flag(name, 1'b0, dmem_we);
      check_flag(name, 1'b0, halted);
      rst_n     = 1'b1;
      prev_addr = imem_addr;
      watched   = 1'b0;
      while (!halted) begin
         // First word fetched after leaving watch_pc
         if (prev_addr == watch_pc && imem_addr != prev_addr) begin
            check_instr(name, watch_word, imem_data);
            watched = 1'b1;
         end
         prev_addr = imem_addr;
         @(posedge clk);
         #1;
      end
      if (watch_pc >= 0 && !watched) begin
         $display("%s never fetched past address %0d", name, watch_pc);
         $display("CHECKS FAILED");
         $fatal(1);
      end
      repeat (10) @(posedge clk);
      #1;
      check_flag(name, 1'b1, halted);
      if (log_addr.size() != exp_addr_q.size()) begin
         $display("%s logged %0d stores but %0d were expected", name, log_addr.size(),
                  exp_addr_q.size());
         $display("CHECKS FAILED");
         $fatal(1);
      end
      foreach (exp_addr_q[k]) begin
         check_addr(name, exp_addr_q[k], log_addr[k]);
         check_data(name, exp_data_q[k], log_data[k]);
      end
   endtask

   initial begin
      rst_n = 1'b0;
      seed  = 32'hfcf6;
      for (int i = 0; i < N_ALU; i++) begin
         if (i < 8) begin
            tc_code[i] = i[4:0];
            tc_a[i]    = -32'sd1234;
            tc_b[i]    = 32'd77;
         end else if (i == 8) begin
            tc_code[i] = 5'd12;
            tc_a[i]    = 32'd500;
            tc_b[i]    = 32'd9;
         end else begin
            tc_code[i] = (i - 9) * 2 + 1;
            tc_a[i]    = $random(seed) % 65536;
            tc_b[i]    = $random(seed) % 65536;
         end
         tc_name[i] = $sformatf("alu_%0d_code_%0d", i, tc_code[i]);
         tc_addr[i] = 16 + i;
         tc_res[i]  = alu_ref(tc_code[i], tc_a[i], tc_b[i]);
      end

      for (int i = 0; i < N_ALU; i++) begin
         clear_program();
         imem[0] = asm_imm(`OP_LOADI, 5'd1, 5'd0, tc_a[i]);
         imem[1] = asm_imm(`OP_LOADI, 5'd2, 5'd0, tc_b[i]);
         imem[2] = asm_alu(5'd3, 5'd1, 5'd2, tc_code[i]);
         imem[3] = asm_imm(`OP_STORE, 5'd3, 5'd0, tc_addr[i]);
         imem[4] = asm_imm(`OP_HALT, 5'd0, 5'd0, '0);
         // Never retires, HALT is older
         imem[5] = asm_imm(`OP_STORE, 5'd3, 5'd0, tc_addr[i] + 32);
         exp_addr_q.push_back(tc_addr[i]);
         exp_data_q.push_back(tc_res[i]);
         run_core(tc_name[i], -1, '0);
      end

      clear_program();
      imem[0] = asm_imm(`OP_LOADI, 5'd4, 5'd0, 32'h0000_5a3c);
      imem[1] = asm_imm(`OP_STORE, 5'd4, 5'd0, 32'd10);
      imem[2] = asm_imm(`OP_LOADI, 5'd5, 5'd0, 32'd4);
      imem[3] = asm_imm(`OP_LOAD, 5'd6, 5'd5, 32'd6);
      imem[4] = asm_imm(`OP_STORE, 5'd6, 5'd5, 32'd16);
      imem[5] = asm_imm(`OP_HALT, 5'd0, 5'd0, '0);
      exp_addr_q = '{32'd10, 32'd20};
      exp_data_q = '{32'h0000_5a3c, 32'h0000_5a3c};
      run_core("load_store", -1, '0);

      clear_program();
      imem[0]  = asm_imm(`OP_LOADI, 5'd1, 5'd0, 32'd0);
      imem[1]  = asm_imm(`OP_LOADI, 5'd2, 5'd0, 32'd8);
      imem[2]  = asm_imm(`OP_JUMPZ, 5'd1, 5'd2, 32'd0);
      imem[3]  = asm_imm(`OP_STORE, 5'd2, 5'd0, 32'd30);
      imem[4]  = asm_imm(`OP_STORE, 5'd2, 5'd0, 32'd31);
      imem[8]  = asm_imm(`OP_LOADI, 5'd3, 5'd0, 32'd5);
      imem[9]  = asm_imm(`OP_JUMPZ, 5'd3, 5'd0, 32'd2);
      imem[10] = asm_imm(`OP_STORE, 5'd3, 5'd0, 32'd32);
      imem[11] = asm_imm(`OP_HALT, 5'd0, 5'd0, '0);
      exp_addr_q = '{32'd32};
      exp_data_q = '{32'd5};
      // Fetch moves from the second dropped word straight to the target
      run_core("jump", 4, asm_imm(`OP_LOADI, 5'd3, 5'd0, 32'd5));

      clear_program();
      imem[0] = asm_imm(`OP_LOADI, 5'd0, 5'd0, 32'd123);
      imem[1] = asm_imm(`OP_STORE, 5'd0, 5'd0, 32'd40);
      imem[2] = asm_imm(`OP_HALT, 5'd0, 5'd0, '0);
      exp_addr_q = '{32'd40};
      exp_data_q = '{32'd0};
      run_core("reg_zero", -1, '0);

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// File: sources.f
+incdir+logic
logic/cpu_pkg.sv
logic/cpu_ifs.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/cpu_top.sv
sim/cpu_tb.sv
